// ==== hw/rx_signal_pkg.sv ====
// Baseband sample and soft-decision types shared by the demodulator and the receiver top level
`default_nettype none

package rx_signal_pkg;

	////////////////////////////////////////
	// Baseband symbols
	////////////////////////////////////////

	// Width of one I or Q component
	localparam int BB_BITS = 7;

	// Signed baseband component, already timed to the symbol
	typedef logic signed [BB_BITS-1:0] sample_t;

	////////////////////////////////////////
	// Demodulator decisions
	////////////////////////////////////////

	// Product width plus one bit for the sum and one for the rotation
	localparam int SOFT_BITS = 2*BB_BITS + 2;

	// Rotated soft decision
	typedef logic signed [SOFT_BITS-1:0] soft_t;

	// Hard bits of one symbol, I in bit 1 and Q in bit 0
	typedef logic [1:0] dibit_t;

endpackage

`default_nettype wire

// ==== hw/rx_frame_pkg.sv ====
// Frame slot, audio sample and output modulator definitions used by frame sync and the PWM stage
`default_nettype none

package rx_frame_pkg;

	////////////////////////////////////////
	// Frame layout
	////////////////////////////////////////

	// Symbols per frame, one of them the marker
	localparam int SLOTS = 4;

	// Slot index within a frame
	typedef logic [$clog2(SLOTS)-1:0] slot_t;

	////////////////////////////////////////
	// Audio samples and modulator
	////////////////////////////////////////

	localparam int AUDIO_BITS = 7;

	// Signed audio sample, two's complement
	typedef logic signed [AUDIO_BITS-1:0] audio_t;

	// Offset that moves a sample into 0 .. 2**AUDIO_BITS-1
	localparam int AUDIO_OFFSET = 2**(AUDIO_BITS-1);

	// Unsigned level and accumulator of the modulator
	typedef logic [AUDIO_BITS-1:0] pwm_level_t;

endpackage

`default_nettype wire

// ==== hw/diff_demod.sv ====
// Differential QPSK demodulator, one shared multiplier per symbol, giving soft and hard decisions
`default_nettype none

module diff_demod
(
	input wire i_clk,
	input wire i_rst_n,
	input wire i_sym_ce,
	input wire rx_signal_pkg::sample_t i_sym_i,
	input wire rx_signal_pkg::sample_t i_sym_q,
	output logic o_dmd_ce,
	output rx_signal_pkg::dibit_t o_dmd_bits,
	output rx_signal_pkg::soft_t o_soft_i,
	output rx_signal_pkg::soft_t o_soft_q
);
	import rx_signal_pkg::*;

	// Multiplier steps with one operand pair each
	typedef enum logic [2:0] {IDLE, II, QQ, IQ, QI} mpy_phase_t;

	// Current and previous symbol
	sample_t cur_i, cur_q;
	sample_t prev_i, prev_q;

	// Sequencer and the step whose product sits in prod
	mpy_phase_t mpy_phase, prod_phase;

	// Operand b is one bit wider so that -(-64) fits
	sample_t op_a;
	logic signed [BB_BITS:0] op_b;
	logic signed [2*BB_BITS:0] prod;

	// re = ci*pi + cq*pq, x = ci*pq - cq*pi
	logic signed [2*BB_BITS:0] acc_re, acc_x;
	logic rot_ce;
	soft_t rot_i, rot_q;

	////////////////////////////////////////
	// Symbol history
	////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n)
		if (!i_rst_n)
		begin
			cur_i <= '0;
			cur_q <= '0;
			prev_i <= '0;
			prev_q <= '0;
		end
		else if (i_sym_ce)
		begin
			prev_i <= cur_i;
			prev_q <= cur_q;
			cur_i <= i_sym_i;
			cur_q <= i_sym_q;
		end

	////////////////////////////////////////
	// Shared multiplier
	////////////////////////////////////////

	// II -> QQ -> IQ -> QI and back to idle
	always_ff @(posedge i_clk or negedge i_rst_n)
		if (!i_rst_n)
		begin
			mpy_phase <= IDLE;
			prod_phase <= IDLE;
		end
		else
		begin
			prod_phase <= mpy_phase;
			case (mpy_phase)
				IDLE: if (i_sym_ce) mpy_phase <= II;
				II: mpy_phase <= QQ;
				QQ: mpy_phase <= IQ;
				IQ: mpy_phase <= QI;
				default: mpy_phase <= IDLE;
			endcase
		end

	// Operand select with the conjugate folded into the QI step
	always_comb
	begin
		op_a = cur_i;
		op_b = {prev_i[BB_BITS-1], prev_i};
		case (mpy_phase)
			QQ:
			begin
				op_a = cur_q;
				op_b = {prev_q[BB_BITS-1], prev_q};
			end
			IQ: op_b = {prev_q[BB_BITS-1], prev_q};
			QI:
			begin
				op_a = cur_q;
				op_b = -$signed({prev_i[BB_BITS-1], prev_i});
			end
			default: op_a = cur_i;
		endcase
	end

	always_ff @(posedge i_clk)
		if (mpy_phase != IDLE)
			prod <= op_a * op_b;

	// Accumulate one step behind the multiplier
	always_ff @(posedge i_clk)
		case (prod_phase)
			II: acc_re <= prod;
			QQ: acc_re <= acc_re + prod;
			IQ: acc_x <= prod;
			QI: acc_x <= acc_x + prod;
			default: acc_x <= acc_x;
		endcase

	////////////////////////////////////////
	// Rotation and slicing
	////////////////////////////////////////

	// Rotate by +45 degrees and take the sign bit as the decision
	assign rot_i = soft_t'(acc_re) + soft_t'(acc_x);
	assign rot_q = soft_t'(acc_x) - soft_t'(acc_re);

	always_ff @(posedge i_clk or negedge i_rst_n)
		if (!i_rst_n)
		begin
			rot_ce <= 1'b0;
			o_dmd_ce <= 1'b0;
		end
		else
		begin
			rot_ce <= (prod_phase == QI);
			o_dmd_ce <= rot_ce;
		end

	// Held until the next symbol
	always_ff @(posedge i_clk)
		if (rot_ce)
		begin
			o_soft_i <= rot_i;
			o_soft_q <= rot_q;
			o_dmd_bits <= {~rot_i[SOFT_BITS-1], ~rot_q[SOFT_BITS-1]};
		end

	// No new symbol until the whole pipe has drained
	a_strobe_spacing: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_sym_ce |-> (mpy_phase == IDLE) && (prod_phase == IDLE) && !rot_ce)
		else $error("symbol strobe while demodulator busy");

	// Four busy steps and back to idle with the decision strobe two cycles later
	a_phase_walk: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_sym_ce |=> (mpy_phase != IDLE) [*4] ##1 (mpy_phase == IDLE) ##2 o_dmd_ce)
		else $error("multiplier phase sequence broken");

endmodule

`default_nettype wire

// ==== hw/frame_sync.sv ====
// Frame marker search, frame position tracking and audio sample assembly from demodulated bits
`default_nettype none

module frame_sync
#(
	parameter int FRAME_CHECK_BITS = 8
)
(
	input wire i_clk,
	input wire i_rst_n,
	input wire i_dmd_ce,
	input wire rx_signal_pkg::dibit_t i_dmd_bits,
	output logic o_frame_ce,
	output rx_frame_pkg::audio_t o_sample,
	output logic o_locked
);
	import rx_frame_pkg::*;

	// Slot of the symbol now arriving
	slot_t slot_cnt;
	slot_t frame_pos;

	// Per-slot confidence
	logic [SLOTS-1:0] frame_match;
	logic [FRAME_CHECK_BITS-1:0] frame_check [SLOTS];

	// Match decode
	slot_t match_slot;
	logic match_one;

	// Marker symbols carry I != Q
	logic marker;

	logic [7:0] frame_sreg;
	logic [7:0] sreg_next;

	assign marker = i_dmd_bits[1] ^ i_dmd_bits[0];

	////////////////////////////////////////
	// Marker search
	////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n)
		if (!i_rst_n)
		begin
			frame_match <= '0;
			for (int k = 0; k < SLOTS; k++)
				frame_check[k] <= '0;
		end
		else if (i_dmd_ce)
		begin
			if (marker)
			begin
				// Full counter, slot is a candidate
				if (&frame_check[slot_cnt])
					frame_match[slot_cnt] <= 1'b1;
				else
					frame_check[slot_cnt] <= frame_check[slot_cnt] + 1'b1;
			end
			else
			begin
				frame_match[slot_cnt] <= 1'b0;
				if (frame_check[slot_cnt] != '0)
					frame_check[slot_cnt] <= frame_check[slot_cnt] - 1'b1;
			end
		end

	// Index of the set flag, and whether it is the only one
	always_comb
	begin
		match_slot = '0;
		for (int k = 0; k < SLOTS; k++)
			if (frame_match[k])
				match_slot = slot_t'(k);
		match_one = (frame_match != '0) && ((frame_match & (frame_match - 1'b1)) == '0);
	end

	////////////////////////////////////////
	// Frame position
	////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n)
		if (!i_rst_n)
		begin
			slot_cnt <= '0;
			frame_pos <= '0;
			o_locked <= 1'b0;
			o_frame_ce <= 1'b0;
		end
		else
		begin
			o_frame_ce <= i_dmd_ce && (slot_cnt == frame_pos);
			if (i_dmd_ce)
			begin
				slot_cnt <= slot_cnt + 1'b1;
				o_locked <= match_one;
				// Ambiguous or no match, keep the old position
				if (match_one)
					frame_pos <= match_slot;
			end
		end

	////////////////////////////////////////
	// Sample assembly
	////////////////////////////////////////

	// I then Q, so Q lands in the LSB
	assign sreg_next = {frame_sreg[5:0], i_dmd_bits};

	always_ff @(posedge i_clk)
		if (i_dmd_ce)
		begin
			frame_sreg <= sreg_next;
			if (slot_cnt == frame_pos)
				o_sample <= sreg_next[AUDIO_BITS-1:0];
		end

	// One frame per SLOTS symbols, never back to back
	a_frame_gap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_frame_ce |=> !o_frame_ce [*3])
		else $error("frame strobes too close");

endmodule

`default_nettype wire

// ==== hw/sigma_delta_pwm.sv ====
// First-order sigma-delta audio output, one bit per clock, driven by the latest frame sample
`default_nettype none

module sigma_delta_pwm
(
	input wire i_clk,
	input wire i_rst_n,
	input wire i_audio_en,
	input wire i_sample_ce,
	input wire rx_frame_pkg::audio_t i_sample,
	output logic o_pwm_audio
);
	import rx_frame_pkg::*;

	audio_t held_sample;
	pwm_level_t level;
	pwm_level_t acc;
	logic [AUDIO_BITS:0] acc_sum;

	always_ff @(posedge i_clk or negedge i_rst_n)
		if (!i_rst_n)
			held_sample <= '0;
		else if (i_sample_ce)
			held_sample <= i_sample;

	// -64..63 becomes 0..127
	assign level = pwm_level_t'(held_sample) + pwm_level_t'(AUDIO_OFFSET);
	assign acc_sum = {1'b0, acc} + {1'b0, level};

	////////////////////////////////////////
	// Modulator
	////////////////////////////////////////

	// Carry out is the pulse, ones ratio is level/128
	always_ff @(posedge i_clk or negedge i_rst_n)
		if (!i_rst_n)
		begin
			acc <= '0;
			o_pwm_audio <= 1'b0;
		end
		else if (i_audio_en)
		begin
			acc <= acc_sum[AUDIO_BITS-1:0];
			o_pwm_audio <= acc_sum[AUDIO_BITS];
		end
		else
		begin
			// Idle, square wave at half the clock
			acc <= '0;
			o_pwm_audio <= !o_pwm_audio;
		end

endmodule

`default_nettype wire

// ==== hw/qpsk_symbol_rcvr.sv ====
// QPSK audio receiver back end, symbols in, demodulated bits, audio samples and PWM audio out
`default_nettype none

module qpsk_symbol_rcvr
#(
	// Width of the per-slot marker confidence counters
	parameter int FRAME_CHECK_BITS = 8
)
(
	input wire i_clk,
	input wire i_rst_n,

	// Timed baseband symbols
	input wire i_sym_ce,
	input wire rx_signal_pkg::sample_t i_sym_i,
	input wire rx_signal_pkg::sample_t i_sym_q,

	// Level enable of the audio output
	input wire i_audio_en,

	// Symbol-rate monitor
	output wire o_dmd_ce,
	output wire rx_signal_pkg::dibit_t o_dmd_bits,

	// Frame-rate audio
	output wire o_frame_ce,
	output wire rx_frame_pkg::audio_t o_sample,
	output wire o_locked,

	output wire o_pwm_audio
);

	////////////////////////////////////////
	// Demodulator, strobe + 6 cycles
	////////////////////////////////////////

	diff_demod u_demod
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_sym_ce(i_sym_ce),
		.i_sym_i(i_sym_i),
		.i_sym_q(i_sym_q),
		.o_dmd_ce(o_dmd_ce),
		.o_dmd_bits(o_dmd_bits),
		// Soft values are a debug tap only
		.o_soft_i(),
		.o_soft_q()
	);

	////////////////////////////////////////
	// Frame sync, one more cycle
	////////////////////////////////////////

	frame_sync
	#(
		.FRAME_CHECK_BITS(FRAME_CHECK_BITS)
	)
	u_sync
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_dmd_ce(o_dmd_ce),
		.i_dmd_bits(o_dmd_bits),
		.o_frame_ce(o_frame_ce),
		.o_sample(o_sample),
		.o_locked(o_locked)
	);

	// Audio output holds the last frame sample
	sigma_delta_pwm u_pwm
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_audio_en(i_audio_en),
		.i_sample_ce(o_frame_ce),
		.i_sample(o_sample),
		.o_pwm_audio(o_pwm_audio)
	);

endmodule

`default_nettype wire

// ==== verification/tb_qpsk_symbol_rcvr.sv ====
// Directed testbench for the QPSK receiver back end, run from tb.f through the Makefile
`default_nettype none

module tb_qpsk_symbol_rcvr;
	import rx_signal_pkg::*;
	import rx_frame_pkg::*;

	localparam int CHECK_BITS = 8;
	localparam int CHECK_MAX = 2**CHECK_BITS - 1;
	localparam int MARK_SLOT = 2;
	localparam int DMD_TIMEOUT = 20;
	localparam int LOCK_LIMIT = 4*(CHECK_MAX + 32);
	localparam int SEED = 32'hc672;

	// Axis points that reach every dibit from any of them
	localparam int AX_I [4] = '{40, 0, -40, 0};
	localparam int AX_Q [4] = '{0, 40, 0, -40};

	logic i_clk;
	logic i_rst_n;
	logic i_sym_ce;
	sample_t i_sym_i;
	sample_t i_sym_q;
	logic i_audio_en;
	logic o_dmd_ce;
	dibit_t o_dmd_bits;
	logic o_frame_ce;
	audio_t o_sample;
	logic o_locked;
	logic o_pwm_audio;

	int checks;
	int errors;

	// Reference copy of the demod history
	int m_prev_i;
	int m_prev_q;

	// Reference frame sync state
	int m_slot;
	int m_pos;
	int m_known;
	int m_check [SLOTS];
	logic [SLOTS-1:0] m_match;
	logic [7:0] m_sreg;

	// Frame strobe seen by the last symbol
	logic seen_ce;
	int seen_slot;

	qpsk_symbol_rcvr
	#(
		.FRAME_CHECK_BITS(CHECK_BITS)
	)
	uut
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_sym_ce(i_sym_ce),
		.i_sym_i(i_sym_i),
		.i_sym_q(i_sym_q),
		.i_audio_en(i_audio_en),
		.o_dmd_ce(o_dmd_ce),
		.o_dmd_bits(o_dmd_bits),
		.o_frame_ce(o_frame_ce),
		.o_sample(o_sample),
		.o_locked(o_locked),
		.o_pwm_audio(o_pwm_audio)
	);

	initial
	begin
		i_clk = 1'b0;
		forever
			#10 i_clk = ~i_clk;
	end

	////////////////////////////////////////
	// Compare helpers
	////////////////////////////////////////

	task automatic dibit_is(input dibit_t got, input dibit_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic audio_is(input audio_t got, input audio_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic flag_is(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic value_near(input int got, input int exp, input int tol, input string what);
		checks++;
		if (got < exp - tol || got > exp + tol)
		begin
			errors++;
			$display("FAILED at %0t: %s is %0d, expected %0d +/- %0d", $time, what, got, exp, tol);
		end
	endtask

	task automatic report_test(input string name, input int start_err);
		if (errors == start_err)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - start_err);
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Conjugate product rotated by +45 degrees and sign sliced
	function automatic dibit_t predict_dibit(input int ci, input int cq, input int pi, input int pq);
		int re;
		int x;
		int si;
		int sq;
		re = ci*pi + cq*pq;
		x = ci*pq - cq*pi;
		si = re + x;
		sq = x - re;
		predict_dibit = {si >= 0, sq >= 0};
	endfunction

	task automatic clear_model;
		m_prev_i = 0;
		m_prev_q = 0;
		m_slot = 0;
		m_pos = 0;
		m_known = 0;
		m_match = '0;
		m_sreg = '0;
		for (int k = 0; k < SLOTS; k++)
			m_check[k] = 0;
	endtask

	// One demodulated symbol into the frame search
	task automatic frame_model_step(input dibit_t bits, output logic exp_ce,
		output audio_t exp_sample, output logic exp_locked);
		int ones;
		int idx;
		ones = 0;
		idx = 0;
		for (int k = 0; k < SLOTS; k++)
			if (m_match[k])
			begin
				ones++;
				idx = k;
			end
		exp_ce = (m_slot == m_pos);
		m_sreg = {m_sreg[5:0], bits};
		exp_sample = audio_t'(m_sreg[6:0]);
		// Position and lock come from the flags before this symbol
		exp_locked = (ones == 1);
		if (ones == 1)
			m_pos = idx;
		if (bits[1] != bits[0])
		begin
			if (m_check[m_slot] == CHECK_MAX)
				m_match[m_slot] = 1'b1;
			else
				m_check[m_slot]++;
		end
		else
		begin
			m_match[m_slot] = 1'b0;
			if (m_check[m_slot] > 0)
				m_check[m_slot]--;
		end
		m_slot = (m_slot + 1) % SLOTS;
		m_known++;
	endtask

	// Marker slot gets differing bits and the others equal or free bits
	function automatic dibit_t next_want(input logic marker, input logic any_data);
		if (marker)
			next_want = ($urandom % 2) ? 2'b10 : 2'b01;
		else if (any_data)
			next_want = dibit_t'($urandom % 4);
		else
			next_want = ($urandom % 2) ? 2'b11 : 2'b00;
	endfunction

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic apply_reset;
		i_rst_n = 1'b0;
		clear_model();
		repeat (2)
			@(negedge i_clk);
		i_rst_n = 1'b1;
	endtask

	// One strobe followed by checks of bits, frame strobe, sample and lock
	task automatic send_symbol(input int ci, input int cq);
		dibit_t exp_bits;
		logic exp_ce;
		logic exp_locked;
		audio_t exp_sample;
		int lat;
		exp_bits = predict_dibit(ci, cq, m_prev_i, m_prev_q);
		m_prev_i = ci;
		m_prev_q = cq;
		seen_ce = 1'b0;
		i_sym_ce = 1'b1;
		i_sym_i = sample_t'(ci);
		i_sym_q = sample_t'(cq);
		@(negedge i_clk);
		i_sym_ce = 1'b0;
		lat = 0;
		while (!o_dmd_ce && lat < DMD_TIMEOUT)
		begin
			@(negedge i_clk);
			lat++;
		end
		if (!o_dmd_ce)
		begin
			errors++;
			$display("Timeout: o_dmd_ce did not follow a symbol strobe within %0d cycles",
				DMD_TIMEOUT);
		end
		else
		begin
			value_near(lat, 6, 0, "o_dmd_ce latency");
			dibit_is(o_dmd_bits, exp_bits, "o_dmd_bits");
			seen_slot = m_slot;
			frame_model_step(exp_bits, exp_ce, exp_sample, exp_locked);
			@(negedge i_clk);
			seen_ce = o_frame_ce;
			flag_is(o_frame_ce, exp_ce, "o_frame_ce");
			flag_is(o_locked, exp_locked, "o_locked");
			// Word valid once four symbols passed the shift register
			if (exp_ce && m_known >= 4)
				audio_is(o_sample, exp_sample, "o_sample");
		end
		// Strobe spacing of 10
		repeat (2)
			@(negedge i_clk);
	endtask

	// Axis point whose product with the previous symbol gives the bits
	task automatic send_bits(input dibit_t want);
		int pick;
		pick = -1;
		for (int k = 0; k < 4; k++)
			if (pick < 0 && predict_dibit(AX_I[k], AX_Q[k], m_prev_i, m_prev_q) == want)
				pick = k;
		if (pick < 0)
		begin
			errors++;
			$display("No axis symbol gives bits %b after the previous symbol", want);
		end
		else
			send_symbol(AX_I[pick], AX_Q[pick]);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic check_idle_after_reset;
		int start_err;
		logic last_pwm;
		start_err = errors;
		apply_reset();
		flag_is(o_pwm_audio, 1'b0, "o_pwm_audio after reset");
		last_pwm = o_pwm_audio;
		repeat (40)
		begin
			@(negedge i_clk);
			flag_is(o_dmd_ce, 1'b0, "idle o_dmd_ce");
			flag_is(o_frame_ce, 1'b0, "idle o_frame_ce");
			flag_is(o_locked, 1'b0, "idle o_locked");
			flag_is(o_pwm_audio, ~last_pwm, "disabled o_pwm_audio toggle");
			last_pwm = o_pwm_audio;
		end
		report_test("reset_idle", start_err);
	endtask

	task automatic check_random_demod;
		int start_err;
		sample_t si;
		sample_t sq;
		start_err = errors;
		repeat (40)
		begin
			si = sample_t'($urandom);
			sq = sample_t'($urandom);
			send_symbol(int'(si), int'(sq));
		end
		report_test("demod_random", start_err);
	endtask

	task automatic acquire_lock;
		int start_err;
		int n;
		int ce_seen;
		start_err = errors;
		n = 0;
		ce_seen = 0;
		// Axis start point
		send_symbol(40, 0);
		while ((m_check[MARK_SLOT] != CHECK_MAX || m_slot != 0) && n < LOCK_LIMIT)
		begin
			send_bits(next_want(m_slot == MARK_SLOT, 1'b0));
			n++;
		end
		if (n >= LOCK_LIMIT)
		begin
			errors++;
			$display("Marker counter of slot %0d never saturated", MARK_SLOT);
		end
		// Saturated counter now sets the match flag
		repeat (SLOTS)
			send_bits(next_want(m_slot == MARK_SLOT, 1'b0));
		flag_is(o_locked, 1'b1, "o_locked after the lock frame");
		repeat (2*SLOTS)
		begin
			send_bits(next_want(m_slot == MARK_SLOT, 1'b0));
			if (seen_ce)
			begin
				ce_seen++;
				value_near(seen_slot, MARK_SLOT, 0, "slot of o_frame_ce");
			end
		end
		value_near(ce_seen, 2, 0, "frame strobes in two frames");
		report_test("frame_lock", start_err);
	endtask

	task automatic check_sample_words;
		int start_err;
		int ce_seen;
		start_err = errors;
		ce_seen = 0;
		repeat (20*SLOTS)
		begin
			send_bits(next_want(m_slot == MARK_SLOT, 1'b1));
			if (seen_ce)
				ce_seen++;
		end
		value_near(ce_seen, 20, 0, "frame strobes in twenty frames");
		flag_is(o_locked, 1'b1, "o_locked with random data");
		report_test("sample_assembly", start_err);
	endtask

	task automatic measure_pwm_duty;
		int start_err;
		int lv;
		int ones;
		audio_t s;
		start_err = errors;
		// Unlocked so the frame strobe sits at slot 0
		apply_reset();
		send_symbol(40, 0);
		for (int k = 0; k < 3; k++)
		begin
			lv = (k == 0) ? -64 : (k == 1) ? 0 : 63;
			s = audio_t'(lv);
			// Slots 1, 2, 3 and 0 fill the word with the Q bit of slot 1 on top
			send_bits({1'b0, s[6]});
			send_bits(s[5:4]);
			send_bits(s[3:2]);
			send_bits(s[1:0]);
			audio_is(o_sample, s, "sample held by the modulator");
			i_audio_en = 1'b1;
			ones = 0;
			repeat (1024)
			begin
				@(negedge i_clk);
				ones = ones + int'(o_pwm_audio);
			end
			value_near(ones, 8*(lv + 64), 2, "ones over 1024 cycles");
			i_audio_en = 1'b0;
		end
		report_test("pwm_duty", start_err);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		i_rst_n = 1'b0;
		i_sym_ce = 1'b0;
		i_sym_i = '0;
		i_sym_q = '0;
		i_audio_en = 1'b0;
		checks = 0;
		errors = 0;
		seen_ce = 1'b0;
		seen_slot = 0;
		void'($urandom(SEED));
		check_idle_after_reset();
		check_random_demod();
		acquire_lock();
		check_sample_words();
		measure_pwm_duty();
		$display("Summary: 5 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/rx_signal_pkg.sv
hw/rx_frame_pkg.sv
hw/diff_demod.sv
hw/frame_sync.sv
hw/sigma_delta_pwm.sv
hw/qpsk_symbol_rcvr.sv
verification/tb_qpsk_symbol_rcvr.sv

// ==== Makefile ====
TOP = tb_qpsk_symbol_rcvr

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
